// ==== include/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data path and address width
`define LSU_DATA_W 32

// word address width of the data RAM, 256 words by default
`define LSU_RAM_AW 8

// width of each fault counter
// two counters share one 32 bit register
`define LSU_CNT_W 16

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build the lsu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f sources.f --top-module lsu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vlsu_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== sources.f ====
+incdir+include
src/lsu_pkg.sv
src/lsu_store_align.sv
src/ex_mem_reg.sv
src/data_ram.sv
src/lsu_load_align.sv
src/lsu_fault_csr.sv
src/lsu_top.sv
verification/lsu_tb.sv

// ==== src/data_ram.sv ====
`timescale 1ns/10ps

`include "lsu_defs.svh"

module data_ram (
    input  logic                   clk,
    input  logic                   ram_en,
    input  logic [3:0]             ram_wen,
    input  logic [`LSU_DATA_W-1:0] ram_addr,
    input  logic [`LSU_DATA_W-1:0] ram_wdata,
    output logic [`LSU_DATA_W-1:0] ram_rdata
);

    localparam int DEPTH = 1 << `LSU_RAM_AW;

    logic [`LSU_DATA_W-1:0] mem [DEPTH];
    logic [`LSU_RAM_AW-1:0] word_idx;

    // byte address in, word index out
    assign word_idx = ram_addr[`LSU_RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_wen[b]) begin
                    mem[word_idx][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                end
            end
        end
    end

    // read returns the word as it was before a same-cycle write
    always_ff @(posedge clk) begin
        if (ram_en) begin
            ram_rdata <= mem[word_idx];
        end
    end

endmodule

// ==== src/ex_mem_reg.sv ====
`timescale 1ns/10ps

`include "lsu_defs.svh"

module ex_mem_reg (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_valid,
    input  lsu_pkg::ls_sel_e       ex_ls_sel,
    input  logic [`LSU_DATA_W-1:0] ex_addr,
    input  logic [`LSU_DATA_W-1:0] ex_rt_data,
    input  logic                   ex_w_reg_ena,
    input  logic [4:0]             ex_w_reg_dst,
    input  logic                   ex_adel,
    input  logic                   ex_ades,
    input  logic                   fault_pending,
    output logic                   mem_valid,
    output lsu_pkg::ls_sel_e       mem_ls_sel,
    output logic [1:0]             mem_addr_lo,
    output logic [`LSU_DATA_W-1:0] mem_rt_data,
    output logic                   mem_w_reg_ena,
    output logic [4:0]             mem_w_reg_dst,
    output logic                   mem_exc
);

    logic w_ena_ok;

    // no writeback for a faulting or blocked access
    assign w_ena_ok = ex_valid & ex_w_reg_ena & ~ex_adel & ~ex_ades & ~fault_pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid     <= 1'b0;
            mem_w_reg_ena <= 1'b0;
            mem_exc       <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_w_reg_ena <= w_ena_ok;
            mem_exc       <= ex_adel | ex_ades;
        end
    end

    always_ff @(posedge clk) begin
        mem_ls_sel    <= ex_ls_sel;
        mem_addr_lo   <= ex_addr[1:0];
        mem_rt_data   <= ex_rt_data;
        mem_w_reg_dst <= ex_w_reg_dst;
    end

endmodule

// ==== src/lsu_fault_csr.sv ====
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_fault_csr (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_adel,
    input  logic                   ex_ades,
    input  logic [`LSU_DATA_W-1:0] ex_addr,
    input  logic                   csr_req,
    input  logic                   csr_we,
    input  lsu_pkg::csr_addr_e     csr_addr,
    input  logic [`LSU_DATA_W-1:0] csr_wdata,
    output logic                   csr_ack,
    output logic [`LSU_DATA_W-1:0] csr_rdata,
    output logic                   fault_pending
);

    logic                   trap_enable;
    logic [`LSU_DATA_W-1:0] badvaddr;
    logic [`LSU_CNT_W-1:0]  adel_cnt;
    logic [`LSU_CNT_W-1:0]  ades_cnt;
    logic                   csr_access;
    logic                   csr_wr;
    logic                   fault;
    logic                   cnt_clr;
    logic                   pend_clr;
    logic [`LSU_DATA_W-1:0] rd_mux;

    // one access per request, taken while ack is still low
    assign csr_access = csr_req & ~csr_ack;
    assign csr_wr     = csr_access & csr_we;
    assign fault      = ex_adel | ex_ades;
    assign cnt_clr    = csr_wr & (csr_addr == lsu_pkg::CSR_FAULT_CNT);
    assign pend_clr   = csr_wr & (csr_addr == lsu_pkg::CSR_STATUS) & csr_wdata[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_ack       <= 1'b0;
            trap_enable   <= 1'b0;
            fault_pending <= 1'b0;
            badvaddr      <= '0;
            adel_cnt      <= '0;
            ades_cnt      <= '0;
        end else begin
            // ack follows req, so it drops the cycle after req is low
            csr_ack <= csr_req;
            if (csr_wr && csr_addr == lsu_pkg::CSR_CTRL) begin
                trap_enable <= csr_wdata[0];
            end
            // a new fault wins over a host clear in the same cycle
            if (fault && trap_enable) begin
                fault_pending <= 1'b1;
            end else if (pend_clr) begin
                fault_pending <= 1'b0;
            end
            if (fault) begin
                badvaddr <= ex_addr;
            end
            if (cnt_clr) begin
                adel_cnt <= `LSU_CNT_W'(ex_adel);
                ades_cnt <= `LSU_CNT_W'(ex_ades);
            end else begin
                if (ex_adel && !(&adel_cnt)) begin
                    adel_cnt <= adel_cnt + 1'b1;
                end
                if (ex_ades && !(&ades_cnt)) begin
                    ades_cnt <= ades_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (csr_addr)
            lsu_pkg::CSR_CTRL:     rd_mux = {31'b0, trap_enable};
            lsu_pkg::CSR_STATUS:   rd_mux = {31'b0, fault_pending};
            lsu_pkg::CSR_BADVADDR: rd_mux = badvaddr;
            default:               rd_mux = {ades_cnt, adel_cnt};
        endcase
    end

    // read data is held for as long as ack stays high
    always_ff @(posedge clk) begin
        if (csr_access) begin
            csr_rdata <= rd_mux;
        end
    end

endmodule

// ==== src/lsu_load_align.sv ====
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_load_align (
    input  logic                   mem_valid,
    input  lsu_pkg::ls_sel_e       mem_ls_sel,
    input  logic [1:0]             mem_addr_lo,
    input  logic [`LSU_DATA_W-1:0] mem_rt_data,
    input  logic [`LSU_DATA_W-1:0] ram_rdata,
    output logic [`LSU_DATA_W-1:0] mem_r_data
);

    logic [7:0]             rd_byte;
    logic [15:0]            rd_half;
    logic [`LSU_DATA_W-1:0] lwl_data;
    logic [`LSU_DATA_W-1:0] lwr_data;

    always_comb begin
        case (mem_addr_lo)
            2'b00: rd_byte = ram_rdata[7:0];
            2'b01: rd_byte = ram_rdata[15:8];
            2'b10: rd_byte = ram_rdata[23:16];
            default: rd_byte = ram_rdata[31:24];
        endcase
    end

    // halfword loads are aligned, bit 1 picks the half
    assign rd_half = mem_addr_lo[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    // lwl fills the top of rt from the addressed byte downward
    always_comb begin
        case (mem_addr_lo)
            2'b00: lwl_data = {ram_rdata[7:0], mem_rt_data[23:0]};
            2'b01: lwl_data = {ram_rdata[15:0], mem_rt_data[15:0]};
            2'b10: lwl_data = {ram_rdata[23:0], mem_rt_data[7:0]};
            default: lwl_data = ram_rdata;
        endcase
    end

    // lwr fills the bottom of rt from the addressed byte upward
    always_comb begin
        case (mem_addr_lo)
            2'b00: lwr_data = ram_rdata;
            2'b01: lwr_data = {mem_rt_data[31:24], ram_rdata[31:8]};
            2'b10: lwr_data = {mem_rt_data[31:16], ram_rdata[31:16]};
            default: lwr_data = {mem_rt_data[31:8], ram_rdata[31:24]};
        endcase
    end

    always_comb begin
        if (!mem_valid) begin
            mem_r_data = '0;
        end else begin
            case (mem_ls_sel)
                lsu_pkg::LS_LB:  mem_r_data = {{24{rd_byte[7]}}, rd_byte};
                lsu_pkg::LS_LBU: mem_r_data = {24'b0, rd_byte};
                lsu_pkg::LS_LH:  mem_r_data = {{16{rd_half[15]}}, rd_half};
                lsu_pkg::LS_LHU: mem_r_data = {16'b0, rd_half};
                lsu_pkg::LS_LW:  mem_r_data = ram_rdata;
                lsu_pkg::LS_LWL: mem_r_data = lwl_data;
                lsu_pkg::LS_LWR: mem_r_data = lwr_data;
                // stores return nothing
                default:         mem_r_data = '0;
            endcase
        end
    end

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    // load/store select, bit 3 set for stores
    typedef enum logic [3:0] {
        LS_LB  = 4'h0,
        LS_LBU = 4'h1,
        LS_LH  = 4'h2,
        LS_LHU = 4'h3,
        LS_LW  = 4'h4,
        LS_LWL = 4'h5,
        LS_LWR = 4'h6,
        LS_SB  = 4'h8,
        LS_SH  = 4'h9,
        LS_SW  = 4'ha,
        LS_SWL = 4'hb,
        LS_SWR = 4'hc
    } ls_sel_e;

    // fault register map on the host port
    typedef enum logic [1:0] {
        CSR_CTRL      = 2'd0,
        CSR_STATUS    = 2'd1,
        CSR_BADVADDR  = 2'd2,
        CSR_FAULT_CNT = 2'd3
    } csr_addr_e;

endpackage

// ==== src/lsu_store_align.sv ====
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_store_align (
    input  logic                   ex_valid,
    input  lsu_pkg::ls_sel_e       ex_ls_sel,
    input  logic [`LSU_DATA_W-1:0] ex_addr,
    input  logic [`LSU_DATA_W-1:0] ex_rt_data,
    input  logic                   fault_pending,
    output logic                   ex_adel,
    output logic                   ex_ades,
    output logic                   ram_en,
    output logic [3:0]             ram_wen,
    output logic [`LSU_DATA_W-1:0] ram_addr,
    output logic [`LSU_DATA_W-1:0] ram_wdata
);

    logic [1:0]             addr_lo;
    logic                   half_mis;
    logic                   word_mis;
    logic [3:0]             wen_raw;
    logic [`LSU_DATA_W-1:0] wdata;

    assign addr_lo  = ex_addr[1:0];
    assign half_mis = addr_lo[0];
    assign word_mis = |addr_lo;

    assign ex_adel = ex_valid & (
        ((ex_ls_sel == lsu_pkg::LS_LH) & half_mis) |
        ((ex_ls_sel == lsu_pkg::LS_LHU) & half_mis) |
        ((ex_ls_sel == lsu_pkg::LS_LW) & word_mis));

    assign ex_ades = ex_valid & (
        ((ex_ls_sel == lsu_pkg::LS_SH) & half_mis) |
        ((ex_ls_sel == lsu_pkg::LS_SW) & word_mis));

    // a pending trapped fault blocks every access
    assign ram_en   = ex_valid & ~ex_adel & ~ex_ades & ~fault_pending;
    assign ram_addr = ram_en ? ex_addr : '0;

    always_comb begin
        wen_raw = 4'b0000;
        wdata   = '0;
        case (ex_ls_sel)
            lsu_pkg::LS_SB: begin
                wen_raw = 4'b0001 << addr_lo;
                wdata   = {4{ex_rt_data[7:0]}};
            end
            lsu_pkg::LS_SH: begin
                wen_raw = addr_lo[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{ex_rt_data[15:0]}};
            end
            lsu_pkg::LS_SW: begin
                wen_raw = 4'b1111;
                wdata   = ex_rt_data;
            end
            // swl writes the high end of rt down to the addressed byte
            lsu_pkg::LS_SWL: begin
                case (addr_lo)
                    2'b00: wdata = {24'b0, ex_rt_data[31:24]};
                    2'b01: wdata = {16'b0, ex_rt_data[31:16]};
                    2'b10: wdata = {8'b0, ex_rt_data[31:8]};
                    default: wdata = ex_rt_data;
                endcase
                wen_raw = 4'b1111 >> (2'd3 - addr_lo);
            end
            // swr writes the low end of rt up from the addressed byte
            lsu_pkg::LS_SWR: begin
                case (addr_lo)
                    2'b00: wdata = ex_rt_data;
                    2'b01: wdata = {ex_rt_data[23:0], 8'b0};
                    2'b10: wdata = {ex_rt_data[15:0], 16'b0};
                    default: wdata = {ex_rt_data[7:0], 24'b0};
                endcase
                wen_raw = 4'b1111 << addr_lo;
            end
            default: begin
                wen_raw = 4'b0000;
                wdata   = '0;
            end
        endcase
    end

    // loads leave wen_raw at zero, so this is also the read/write select
    assign ram_wen   = ram_en ? wen_raw : 4'b0000;
    assign ram_wdata = wdata;

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_valid,
    input  lsu_pkg::ls_sel_e       ex_ls_sel,
    input  logic [`LSU_DATA_W-1:0] ex_addr,
    input  logic [`LSU_DATA_W-1:0] ex_rt_data,
    input  logic                   ex_w_reg_ena,
    input  logic [4:0]             ex_w_reg_dst,
    output logic                   mem_valid,
    output logic [`LSU_DATA_W-1:0] mem_r_data,
    output logic                   mem_w_reg_ena,
    output logic [4:0]             mem_w_reg_dst,
    output logic                   mem_exc,
    input  logic                   csr_req,
    input  logic                   csr_we,
    input  lsu_pkg::csr_addr_e     csr_addr,
    input  logic [`LSU_DATA_W-1:0] csr_wdata,
    output logic                   csr_ack,
    output logic [`LSU_DATA_W-1:0] csr_rdata
);

    logic                   ex_adel;
    logic                   ex_ades;
    logic                   fault_pending;
    logic                   ram_en;
    logic [3:0]             ram_wen;
    logic [`LSU_DATA_W-1:0] ram_addr;
    logic [`LSU_DATA_W-1:0] ram_wdata;
    logic [`LSU_DATA_W-1:0] ram_rdata;
    lsu_pkg::ls_sel_e       mem_ls_sel;
    logic [1:0]             mem_addr_lo;
    logic [`LSU_DATA_W-1:0] mem_rt_data;

    lsu_store_align u_store_align (
        .ex_valid      (ex_valid),
        .ex_ls_sel     (ex_ls_sel),
        .ex_addr       (ex_addr),
        .ex_rt_data    (ex_rt_data),
        .fault_pending (fault_pending),
        .ex_adel       (ex_adel),
        .ex_ades       (ex_ades),
        .ram_en        (ram_en),
        .ram_wen       (ram_wen),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_valid      (ex_valid),
        .ex_ls_sel     (ex_ls_sel),
        .ex_addr       (ex_addr),
        .ex_rt_data    (ex_rt_data),
        .ex_w_reg_ena  (ex_w_reg_ena),
        .ex_w_reg_dst  (ex_w_reg_dst),
        .ex_adel       (ex_adel),
        .ex_ades       (ex_ades),
        .fault_pending (fault_pending),
        .mem_valid     (mem_valid),
        .mem_ls_sel    (mem_ls_sel),
        .mem_addr_lo   (mem_addr_lo),
        .mem_rt_data   (mem_rt_data),
        .mem_w_reg_ena (mem_w_reg_ena),
        .mem_w_reg_dst (mem_w_reg_dst),
        .mem_exc       (mem_exc)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_wen   (ram_wen),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    lsu_load_align u_load_align (
        .mem_valid   (mem_valid),
        .mem_ls_sel  (mem_ls_sel),
        .mem_addr_lo (mem_addr_lo),
        .mem_rt_data (mem_rt_data),
        .ram_rdata   (ram_rdata),
        .mem_r_data  (mem_r_data)
    );

    lsu_fault_csr u_fault_csr (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_adel       (ex_adel),
        .ex_ades       (ex_ades),
        .ex_addr       (ex_addr),
        .csr_req       (csr_req),
        .csr_we        (csr_we),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .csr_ack       (csr_ack),
        .csr_rdata     (csr_rdata),
        .fault_pending (fault_pending)
    );

endmodule

// ==== verification/lsu_tb.sv ====
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 5;
    localparam int NUM_WORDS  = 16;
    localparam int SEED       = 32'h69868206;
    // the tests need about 220 cycles, the rest is margin
    localparam int MAX_CYCLES = 2000;

    logic                   clk;
    logic                   arst_n;
    logic                   ex_valid;
    lsu_pkg::ls_sel_e       ex_ls_sel;
    logic [`LSU_DATA_W-1:0] ex_addr;
    logic [`LSU_DATA_W-1:0] ex_rt_data;
    logic                   ex_w_reg_ena;
    logic [4:0]             ex_w_reg_dst;
    logic                   mem_valid;
    logic [`LSU_DATA_W-1:0] mem_r_data;
    logic                   mem_w_reg_ena;
    logic [4:0]             mem_w_reg_dst;
    logic                   mem_exc;
    logic                   csr_req;
    logic                   csr_we;
    lsu_pkg::csr_addr_e     csr_addr;
    logic [`LSU_DATA_W-1:0] csr_wdata;
    logic                   csr_ack;
    logic [`LSU_DATA_W-1:0] csr_rdata;

    // byte model of the low words of the RAM
    logic [7:0]  model [NUM_WORDS*4];
    // one entry per access: {check data, exc, w_reg_ena, w_reg_dst, data}
    logic [39:0] exp_q [$];
    int          issue_cyc_q [$];
    int          cycle = 0;
    int          n_seen = 0;
    int          data_errs = 0;
    int          host_errs = 0;
    logic        trap_on;
    logic        pend;
    int          adel_seen;
    int          ades_seen;
    logic [31:0] last_bad;

    lsu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
    end

    function automatic logic is_load(lsu_pkg::ls_sel_e op);
        return op inside {lsu_pkg::LS_LB, lsu_pkg::LS_LBU, lsu_pkg::LS_LH, lsu_pkg::LS_LHU,
                          lsu_pkg::LS_LW, lsu_pkg::LS_LWL, lsu_pkg::LS_LWR};
    endfunction

    function automatic logic misaligned(lsu_pkg::ls_sel_e op, logic [31:0] addr);
        case (op)
            lsu_pkg::LS_LH, lsu_pkg::LS_LHU, lsu_pkg::LS_SH: return addr[0];
            lsu_pkg::LS_LW, lsu_pkg::LS_SW: return addr[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // naturally aligned random address inside the modelled words
    function automatic logic [31:0] rand_addr(lsu_pkg::ls_sel_e op);
        logic [31:0] a;
        a = 32'($urandom_range(NUM_WORDS*4-1, 0));
        case (op)
            lsu_pkg::LS_LH, lsu_pkg::LS_LHU, lsu_pkg::LS_SH: a[0] = 1'b0;
            lsu_pkg::LS_LW, lsu_pkg::LS_SW: a[1:0] = 2'b00;
            default: a = a;
        endcase
        return a;
    endfunction

    function automatic lsu_pkg::ls_sel_e rand_store_op();
        case ($urandom_range(3, 0))
            0: return lsu_pkg::LS_SB;
            1: return lsu_pkg::LS_SH;
            2: return lsu_pkg::LS_SWL;
            default: return lsu_pkg::LS_SWR;
        endcase
    endfunction

    function automatic lsu_pkg::ls_sel_e rand_load_op();
        case ($urandom_range(5, 0))
            0: return lsu_pkg::LS_LB;
            1: return lsu_pkg::LS_LBU;
            2: return lsu_pkg::LS_LH;
            3: return lsu_pkg::LS_LHU;
            4: return lsu_pkg::LS_LWL;
            default: return lsu_pkg::LS_LWR;
        endcase
    endfunction

    function automatic logic [31:0] predict_load(lsu_pkg::ls_sel_e op, logic [31:0] addr,
                                                 logic [31:0] rt);
        logic [31:0] w;
        logic [31:0] keep;
        logic [7:0]  b;
        int          base;
        int          k;
        base = int'(addr[5:2]) * 4;
        k    = int'(addr[1:0]);
        w    = {model[base+3], model[base+2], model[base+1], model[base]};
        b    = model[base+k];
        case (op)
            lsu_pkg::LS_LB:  return {{24{b[7]}}, b};
            lsu_pkg::LS_LBU: return {24'h0, b};
            lsu_pkg::LS_LH:  return {{16{model[base+k+1][7]}}, model[base+k+1], model[base+k]};
            lsu_pkg::LS_LHU: return {16'h0, model[base+k+1], model[base+k]};
            lsu_pkg::LS_LW:  return w;
            // memory bytes 0..k land in the top of rt
            lsu_pkg::LS_LWL: begin
                keep = 32'hffffffff >> (8 * (k + 1));
                return (w << (8 * (3 - k))) | (rt & keep);
            end
            lsu_pkg::LS_LWR: begin
                keep = ~(32'hffffffff >> (8 * k));
                return (w >> (8 * k)) | (rt & keep);
            end
            default: return 32'h0;
        endcase
    endfunction

    function automatic void update_model(lsu_pkg::ls_sel_e op, logic [31:0] addr,
                                         logic [31:0] rt);
        int base;
        int k;
        int i;
        base = int'(addr[5:2]) * 4;
        k    = int'(addr[1:0]);
        case (op)
            lsu_pkg::LS_SB: model[base+k] = rt[7:0];
            lsu_pkg::LS_SH: begin
                model[base+k]   = rt[7:0];
                model[base+k+1] = rt[15:8];
            end
            lsu_pkg::LS_SW:  for (i = 0; i < 4; i++) model[base+i] = rt[8*i +: 8];
            lsu_pkg::LS_SWL: for (i = 0; i <= k; i++) model[base+i] = rt[8*(3-k+i) +: 8];
            lsu_pkg::LS_SWR: for (i = k; i < 4; i++) model[base+i] = rt[8*(i-k) +: 8];
            default: ;
        endcase
    endfunction

    task automatic issue(input lsu_pkg::ls_sel_e op, input logic [31:0] addr,
                         input logic [31:0] rt);
        logic        load;
        logic        bad;
        logic        go;
        logic [31:0] exp_data;
        load     = is_load(op);
        bad      = misaligned(op, addr);
        go       = !bad && !pend;
        exp_data = (load && go) ? predict_load(op, addr, rt) : 32'h0;
        ex_valid     = 1'b1;
        ex_ls_sel    = op;
        ex_addr      = addr;
        ex_rt_data   = rt;
        ex_w_reg_ena = load;
        ex_w_reg_dst = 5'($urandom);
        // a dropped load leaves the read data unknown
        exp_q.push_back({go || !load, bad, load && go, ex_w_reg_dst, exp_data});
        issue_cyc_q.push_back(cycle);
        if (!load && go) begin
            update_model(op, addr, rt);
        end
        if (bad) begin
            if (load) adel_seen++;
            else ades_seen++;
            last_bad = addr;
            if (trap_on) pend = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle(input int n);
        ex_valid     = 1'b0;
        ex_w_reg_ena = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic expect_low(input string name, input logic val);
        if (val !== 1'b0) begin
            $display("CHECK FAILED at %0t: %s expected 0 got %b", $time, name, val);
            host_errs++;
        end
    endtask

    // four-phase host transfer, started at the drive point of a cycle
    task automatic csr_transfer(input logic we, input lsu_pkg::csr_addr_e addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        rdata     = 32'h0;
        csr_req   = 1'b1;
        csr_we    = we;
        csr_addr  = addr;
        csr_wdata = wdata;
        n = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end while (!csr_ack && n < 4);
        if (!csr_ack) begin
            $display("ERROR at %0t: csr_ack did not come within 4 cycles", $time);
            host_errs++;
        end else begin
            if (n != 1) begin
                $display("ERROR at %0t: csr_ack took %0d cycles instead of 1", $time, n);
                host_errs++;
            end
            rdata = csr_rdata;
        end
        @(posedge clk);
        #DRIVE_DLY;
        csr_req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end while (csr_ack && n < 4);
        if (csr_ack) begin
            $display("ERROR at %0t: csr_ack stayed high after csr_req fell", $time);
            host_errs++;
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic csr_write(input lsu_pkg::csr_addr_e addr, input logic [31:0] data);
        logic [31:0] rd;
        csr_transfer(1'b1, addr, data, rd);
    endtask

    task automatic csr_read(input lsu_pkg::csr_addr_e addr, input logic [31:0] exp,
                            input string label);
        logic [31:0] rd;
        csr_transfer(1'b0, addr, 32'h0, rd);
        if (rd !== exp) begin
            $display("CHECK FAILED at %0t: csr_rdata (%s) expected %h got %h",
                     $time, label, exp, rd);
            host_errs++;
        end
    endtask

    always @(negedge clk) begin : compare
        logic [39:0] e;
        if (arst_n && mem_valid) begin
            if (n_seen >= exp_q.size()) begin
                $display("ERROR at %0t: mem_valid high with no access outstanding", $time);
                data_errs++;
            end else begin
                e = exp_q[n_seen];
                if (cycle != issue_cyc_q[n_seen] + 1) begin
                    $display("ERROR at %0t: result came %0d cycles after issue",
                             $time, cycle - issue_cyc_q[n_seen]);
                    data_errs++;
                end
                if (e[39] && mem_r_data !== e[31:0]) begin
                    $display("CHECK FAILED at %0t: mem_r_data expected %h got %h",
                             $time, e[31:0], mem_r_data);
                    data_errs++;
                end
                if (mem_exc !== e[38]) begin
                    $display("CHECK FAILED at %0t: mem_exc expected %b got %b",
                             $time, e[38], mem_exc);
                    data_errs++;
                end
                if (mem_w_reg_ena !== e[37]) begin
                    $display("CHECK FAILED at %0t: mem_w_reg_ena expected %b got %b",
                             $time, e[37], mem_w_reg_ena);
                    data_errs++;
                end
                if (mem_w_reg_dst !== e[36:32]) begin
                    $display("CHECK FAILED at %0t: mem_w_reg_dst expected %h got %h",
                             $time, e[36:32], mem_w_reg_dst);
                    data_errs++;
                end
                n_seen++;
            end
        end else if (arst_n && mem_r_data !== 32'h0) begin
            // an empty mem slot returns zero
            $display("CHECK FAILED at %0t: mem_r_data expected %h got %h",
                     $time, 32'h0, mem_r_data);
            data_errs++;
        end
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        $display("ERROR: run stopped at the limit of %0d cycles", MAX_CYCLES);
        $display("errors: %0d data path, %0d host port", data_errs, host_errs);
        $display("test failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]      a;
        lsu_pkg::ls_sel_e op;
        int               i;
        void'($urandom(SEED));
        arst_n       = 1'b0;
        ex_valid     = 1'b0;
        ex_ls_sel    = lsu_pkg::LS_LW;
        ex_addr      = 32'h0;
        ex_rt_data   = 32'h0;
        ex_w_reg_ena = 1'b0;
        ex_w_reg_dst = 5'h0;
        csr_req      = 1'b0;
        csr_we       = 1'b0;
        csr_addr     = lsu_pkg::CSR_CTRL;
        csr_wdata    = 32'h0;
        trap_on      = 1'b0;
        pend         = 1'b0;
        adel_seen    = 0;
        ades_seen    = 0;
        last_bad     = 32'h0;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        expect_low("mem_valid", mem_valid);
        expect_low("mem_exc", mem_exc);
        expect_low("mem_w_reg_ena", mem_w_reg_ena);
        expect_low("csr_ack", csr_ack);
        csr_read(lsu_pkg::CSR_CTRL, 32'h0, "ctrl after reset");
        csr_read(lsu_pkg::CSR_FAULT_CNT, 32'h0, "fault count after reset");

        // fill the modelled words, then store/load pairs at random words
        for (i = 0; i < NUM_WORDS; i++) begin
            issue(lsu_pkg::LS_SW, 32'(i * 4), $urandom);
        end
        for (i = 0; i < 12; i++) begin
            a = rand_addr(lsu_pkg::LS_SW);
            issue(lsu_pkg::LS_SW, a, $urandom);
            issue(lsu_pkg::LS_LW, a, $urandom);
        end
        idle(2);

        // partial stores, then partial loads with rt merge
        for (i = 0; i < 40; i++) begin
            op = rand_store_op();
            issue(op, rand_addr(op), $urandom);
        end
        for (i = 0; i < 40; i++) begin
            op = rand_load_op();
            issue(op, rand_addr(op), $urandom);
        end
        // back to back word loads
        for (i = 0; i < 16; i++) begin
            issue(lsu_pkg::LS_LW, rand_addr(lsu_pkg::LS_LW), $urandom);
        end
        idle(2);

        // misaligned accesses with trapping off
        a = rand_addr(lsu_pkg::LS_SW);
        issue(lsu_pkg::LS_LH, a | 32'h1, $urandom);
        issue(lsu_pkg::LS_LW, a | 32'h2, $urandom);
        issue(lsu_pkg::LS_SH, a | 32'h3, $urandom);
        issue(lsu_pkg::LS_SW, a | 32'h1, $urandom);
        issue(lsu_pkg::LS_LW, a, $urandom);
        idle(2);
        csr_read(lsu_pkg::CSR_FAULT_CNT, {`LSU_CNT_W'(ades_seen), `LSU_CNT_W'(adel_seen)},
                 "fault count");
        csr_read(lsu_pkg::CSR_BADVADDR, last_bad, "badvaddr");
        csr_read(lsu_pkg::CSR_STATUS, 32'h0, "status with trap off");

        // trapped fault blocks the following accesses until cleared
        csr_write(lsu_pkg::CSR_CTRL, 32'h1);
        trap_on = 1'b1;
        a = rand_addr(lsu_pkg::LS_SW);
        issue(lsu_pkg::LS_LW, a | 32'h2, $urandom);
        issue(lsu_pkg::LS_SW, a, $urandom);
        issue(lsu_pkg::LS_LBU, a, $urandom);
        idle(2);
        csr_read(lsu_pkg::CSR_STATUS, 32'h1, "status after trap");
        csr_read(lsu_pkg::CSR_BADVADDR, last_bad, "badvaddr after trap");
        csr_write(lsu_pkg::CSR_STATUS, 32'h1);
        pend = 1'b0;
        csr_read(lsu_pkg::CSR_STATUS, 32'h0, "status after clear");
        issue(lsu_pkg::LS_LW, a, $urandom);
        issue(lsu_pkg::LS_SW, a, $urandom);
        issue(lsu_pkg::LS_LW, a, $urandom);
        idle(2);
        csr_read(lsu_pkg::CSR_CTRL, 32'h1, "ctrl");
        csr_read(lsu_pkg::CSR_FAULT_CNT, {`LSU_CNT_W'(ades_seen), `LSU_CNT_W'(adel_seen)},
                 "fault count with trap on");

        // counter clear and trap disable
        csr_write(lsu_pkg::CSR_FAULT_CNT, 32'h0);
        adel_seen = 0;
        ades_seen = 0;
        csr_read(lsu_pkg::CSR_FAULT_CNT, 32'h0, "fault count after clear");
        csr_write(lsu_pkg::CSR_CTRL, 32'h0);
        trap_on = 1'b0;
        csr_read(lsu_pkg::CSR_CTRL, 32'h0, "ctrl after disable");
        idle(3);

        if (n_seen != exp_q.size()) begin
            $display("ERROR: %0d of %0d results never appeared", exp_q.size() - n_seen,
                     exp_q.size());
            data_errs++;
        end
        $display("errors: %0d data path, %0d host port", data_errs, host_errs);
        if (data_errs == 0 && host_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
